//--- src/ntm_gate_pkg.sv
// Shared fixed-point types and constants for the NTM output gate datapath
// Imported by every module that handles terms, sums or gate values

package ntm_gate_pkg;

  //////////////////////////////////////////////////////////////////////
  // Fixed-point types
  //////////////////////////////////////////////////////////////////////

  // Q8.8 signed value
  // Used for weights, operands, bias and gate output
  typedef logic signed [15:0] data_t;

  // Wide accumulator, still scaled as Q8.8
  // Headroom for long rows and for the three-way gate sum
  typedef logic signed [31:0] acc_t;

  //////////////////////////////////////////////////////////////////////
  // Term stream
  //////////////////////////////////////////////////////////////////////

  // One multiply-accumulate term
  // last marks the final term of a row
  typedef struct packed {
    data_t weight;
    data_t operand;
    logic  last;
  } mac_term_t;

  //////////////////////////////////////////////////////////////////////
  // Hard sigmoid constants
  //////////////////////////////////////////////////////////////////////

  // Upper clamp, 1.0 in Q8.8
  localparam data_t GATE_ONE = 16'h0100;

  // Offset added after the slope, 0.5 in Q8.8
  localparam data_t GATE_HALF = 16'h0080;

endpackage

//--- src/ntm_mac_row.sv
// Multiply-accumulate engine for one matrix-vector row in Q8.8
// Emits the row sum one cycle after the term flagged as last

`timescale 1ns/1ps

module ntm_mac_row (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     start,
  input  logic                     term_enable,
  input  ntm_gate_pkg::mac_term_t  term,
  output logic                     row_sum_enable,
  output ntm_gate_pkg::acc_t       row_sum
);

  import ntm_gate_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Product and rescale
  //////////////////////////////////////////////////////////////////////

  // Full Q16.16 product of two Q8.8 values
  logic signed [31:0] product;
  // Product brought back to Q8.8
  acc_t term_scaled;
  // Running sum including the current term
  acc_t acc_next;
  // Partial sum of the row being received
  acc_t acc;

  assign product     = $signed(term.weight) * $signed(term.operand);
  // Arithmetic shift keeps the sign of negative products
  assign term_scaled = product >>> 8;
  assign acc_next    = acc + term_scaled;

  //////////////////////////////////////////////////////////////////////
  // Accumulator and row sum strobe
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc            <= '0;
      row_sum_enable <= 1'b0;
    end else begin
      row_sum_enable <= 1'b0;
      if (start) begin
        // New gate vector drops any partial row
        acc <= '0;
      end else if (term_enable) begin
        if (term.last) begin
          // Row done, next term starts from zero
          acc            <= '0;
          row_sum_enable <= 1'b1;
        end else begin
          acc <= acc_next;
        end
      end
    end
  end

  // Finished total, only meaningful with row_sum_enable
  always_ff @(posedge CLK) begin
    if (!start && term_enable && term.last) begin
      row_sum <= acc_next;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Term strobe must be driven once out of reset
  a_term_enable_known : assert property (
    @(posedge CLK) disable iff (RST) !$isunknown(term_enable)
  );

endmodule

//--- src/ntm_sum_queue.sv
// Small circular FIFO for row sums or biases waiting on the combiner
// Payload type is a parameter, head entry is visible without a pop

`timescale 1ns/1ps

module ntm_sum_queue #(
  parameter type T           = logic [31:0],
  parameter int  QUEUE_DEPTH = 4
) (
  input  logic CLK,
  input  logic RST,
  input  logic push,
  input  T     push_data,
  input  logic pop,
  output T     pop_data,
  output logic not_empty
);

  // Pointer and occupancy widths
  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  //////////////////////////////////////////////////////////////////////
  // Storage and pointers
  //////////////////////////////////////////////////////////////////////

  T               mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;

  assign not_empty = (count != '0);
  assign full      = (count == CNT_W'(QUEUE_DEPTH));
  // Head of queue shown combinationally
  assign pop_data  = mem[rd_ptr];

  // Entry write
  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap at the depth, which need not be a power of two
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // No back-pressure upstream, a full queue must be draining
  a_no_overflow : assert property (
    @(posedge CLK) disable iff (RST) push |-> (!full || pop)
  );

  a_no_underflow : assert property (
    @(posedge CLK) disable iff (RST) pop |-> not_empty
  );

endmodule

//--- src/ntm_gate_combiner.sv
// Joins feed-forward sum, recurrent sum and bias per row into one gate value
// Applies the hard sigmoid and flags the last row of the vector with ready

`timescale 1ns/1ps

module ntm_gate_combiner #(
  parameter int L_SIZE      = 4,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                CLK,
  input  logic                RST,
  input  logic                start,
  input  logic                ff_sum_enable,
  input  ntm_gate_pkg::acc_t  ff_sum,
  input  logic                rec_sum_enable,
  input  ntm_gate_pkg::acc_t  rec_sum,
  input  logic                bias_enable,
  input  ntm_gate_pkg::data_t bias_in,
  output logic                o_out_enable,
  output ntm_gate_pkg::data_t o_out,
  output logic                ready
);

  import ntm_gate_pkg::*;

  localparam int ROW_W = (L_SIZE > 1) ? $clog2(L_SIZE) : 1;

  //////////////////////////////////////////////////////////////////////
  // Row queues
  //////////////////////////////////////////////////////////////////////

  acc_t  ff_head;
  acc_t  rec_head;
  data_t bias_head;
  logic  ff_not_empty;
  logic  rec_not_empty;
  logic  bias_not_empty;
  // All three parts of the same row are present
  logic  pop_all;

  assign pop_all = ff_not_empty && rec_not_empty && bias_not_empty;

  ntm_sum_queue #(.T(acc_t), .QUEUE_DEPTH(QUEUE_DEPTH)) u_ff_queue (
    .CLK       (CLK),
    .RST       (RST),
    .push      (ff_sum_enable),
    .push_data (ff_sum),
    .pop       (pop_all),
    .pop_data  (ff_head),
    .not_empty (ff_not_empty)
  );

  ntm_sum_queue #(.T(acc_t), .QUEUE_DEPTH(QUEUE_DEPTH)) u_rec_queue (
    .CLK       (CLK),
    .RST       (RST),
    .push      (rec_sum_enable),
    .push_data (rec_sum),
    .pop       (pop_all),
    .pop_data  (rec_head),
    .not_empty (rec_not_empty)
  );

  ntm_sum_queue #(.T(data_t), .QUEUE_DEPTH(QUEUE_DEPTH)) u_bias_queue (
    .CLK       (CLK),
    .RST       (RST),
    .push      (bias_enable),
    .push_data (bias_in),
    .pop       (pop_all),
    .pop_data  (bias_head),
    .not_empty (bias_not_empty)
  );

  //////////////////////////////////////////////////////////////////////
  // Hard sigmoid, y = s/4 + 0.5 clamped to [0, 1]
  //////////////////////////////////////////////////////////////////////

  acc_t  gate_sum;
  acc_t  gate_wide;
  data_t gate_value;

  // Bias sign-extended into the accumulator width
  assign gate_sum  = ff_head + rec_head + acc_t'(bias_head);
  assign gate_wide = (gate_sum >>> 2) + acc_t'(GATE_HALF);

  always_comb begin
    if (gate_wide < 0) begin
      gate_value = '0;
    end else if (gate_wide > acc_t'(GATE_ONE)) begin
      gate_value = GATE_ONE;
    end else begin
      gate_value = data_t'(gate_wide);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output register and row counter
  //////////////////////////////////////////////////////////////////////

  logic [ROW_W-1:0] row_cnt;
  logic             last_row;

  assign last_row = (row_cnt == ROW_W'(L_SIZE - 1));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      o_out_enable <= 1'b0;
      o_out        <= '0;
      ready        <= 1'b0;
      row_cnt      <= '0;
    end else begin
      o_out_enable <= pop_all;
      ready        <= pop_all && last_row && !start;
      if (pop_all) begin
        o_out <= gate_value;
      end
      // start restarts the count, queued rows stay put
      if (start) begin
        row_cnt <= '0;
      end else if (pop_all) begin
        row_cnt <= last_row ? '0 : row_cnt + 1'b1;
      end
    end
  end

  // Clamp must hold on every presented gate
  a_gate_in_range : assert property (
    @(posedge CLK) disable iff (RST)
      o_out_enable |-> (!o_out[15] && (o_out <= GATE_ONE))
  );

endmodule

//--- src/ntm_output_gate.sv
// Top level of the NTM output gate, o = hard_sigmoid(W*x + U*h + b) per row
// Two term engines run side by side and feed one combiner

`timescale 1ns/1ps

module ntm_output_gate #(
  parameter int L_SIZE      = 4,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     start,
  input  logic                     ff_term_enable,
  input  ntm_gate_pkg::mac_term_t  ff_term,
  input  logic                     rec_term_enable,
  input  ntm_gate_pkg::mac_term_t  rec_term,
  input  logic                     bias_enable,
  input  ntm_gate_pkg::data_t      bias_in,
  output logic                     o_out_enable,
  output ntm_gate_pkg::data_t      o_out,
  output logic                     ready
);

  import ntm_gate_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Row sums between engines and combiner
  //////////////////////////////////////////////////////////////////////

  logic ff_sum_enable;
  acc_t ff_sum;
  logic rec_sum_enable;
  acc_t rec_sum;

  // Feed-forward terms W*x
  ntm_mac_row u_ff_row (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .term_enable    (ff_term_enable),
    .term           (ff_term),
    .row_sum_enable (ff_sum_enable),
    .row_sum        (ff_sum)
  );

  // Recurrent terms U*h
  ntm_mac_row u_rec_row (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .term_enable    (rec_term_enable),
    .term           (rec_term),
    .row_sum_enable (rec_sum_enable),
    .row_sum        (rec_sum)
  );

  // Row pairing, bias add, sigmoid and ready
  ntm_gate_combiner #(
    .L_SIZE      (L_SIZE),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_combiner (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .ff_sum_enable  (ff_sum_enable),
    .ff_sum         (ff_sum),
    .rec_sum_enable (rec_sum_enable),
    .rec_sum        (rec_sum),
    .bias_enable    (bias_enable),
    .bias_in        (bias_in),
    .o_out_enable   (o_out_enable),
    .o_out          (o_out),
    .ready          (ready)
  );

endmodule

//--- tests/ntm_output_gate_tb.sv
// Self-checking testbench for the NTM output gate
// Replays the vector file with random idle gaps, checks every gate value and ready

`timescale 1ns/1ps

module ntm_output_gate_tb;

  import ntm_gate_pkg::*;

  localparam int L_SIZE        = 4;
  localparam int QUEUE_DEPTH   = 4;
  localparam int RESET_CYCLES  = 16;
  localparam int DRAIN_TIMEOUT = 200;
  localparam int QUIET_CYCLES  = 8;

  logic      CLK = 1'b0;
  logic      RST;
  logic      start;
  logic      ff_term_enable;
  mac_term_t ff_term;
  logic      rec_term_enable;
  mac_term_t rec_term;
  logic      bias_enable;
  data_t     bias_in;
  logic      o_out_enable;
  data_t     o_out;
  logic      ready;

  // Gates seen by the monitor, ready sampled with each one
  data_t got_gate[$];
  logic  got_ready[$];
  int    stray_ready;
  // Gates still expected for the open test
  data_t exp_gate[$];

  int    checked;
  int    stray_seen;
  int    test_errors;
  int    tests_passed;
  int    tests_failed;
  int    test_id;
  string test_name;
  logic  test_open;

  // 4 ns period
  always begin
    #2 CLK = ~CLK;
  end

  ntm_output_gate #(
    .L_SIZE      (L_SIZE),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_dut (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .ff_term_enable  (ff_term_enable),
    .ff_term         (ff_term),
    .rec_term_enable (rec_term_enable),
    .rec_term        (rec_term),
    .bias_enable     (bias_enable),
    .bias_in         (bias_in),
    .o_out_enable    (o_out_enable),
    .o_out           (o_out),
    .ready           (ready)
  );

  // Outputs sampled mid-cycle, away from the driving edge
  always @(negedge CLK) begin
    if (!RST) begin
      if (o_out_enable) begin
        got_gate.push_back(o_out);
        got_ready.push_back(ready);
      end else if (ready) begin
        stray_ready = stray_ready + 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks and stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("** Error: %0s = 0x%0h, expected 0x%0h", name, got, expected);
      test_errors++;
    end
  endtask

  task automatic drive_idle(input int cycles);
    repeat (cycles) begin
      @(posedge CLK);
      start           <= 1'b0;
      ff_term_enable  <= 1'b0;
      rec_term_enable <= 1'b0;
      bias_enable     <= 1'b0;
    end
  endtask

  task automatic drive_record(input logic ff_en, input data_t ff_w, input data_t ff_op,
                              input logic ff_last, input logic rec_en, input data_t rec_w,
                              input data_t rec_op, input logic rec_last, input logic b_en,
                              input data_t bias);
    @(posedge CLK);
    ff_term_enable  <= ff_en;
    ff_term         <= '{weight: ff_w, operand: ff_op, last: ff_last};
    rec_term_enable <= rec_en;
    rec_term        <= '{weight: rec_w, operand: rec_op, last: rec_last};
    bias_enable     <= b_en;
    bias_in         <= bias;
  endtask

  task automatic report_test();
    if (test_errors == 0) begin
      $display("test %0d %0s: ok", test_id, test_name);
      tests_passed++;
    end else begin
      $display("test %0d %0s: %0d errors", test_id, test_name, test_errors);
      tests_failed++;
    end
  endtask

  // New vector, one start pulse while the design is idle
  task automatic open_test(input int id, input string name);
    test_id     = id;
    test_name   = name;
    test_errors = 0;
    test_open   = 1'b1;
    exp_gate.delete();
    @(posedge CLK);
    start           <= 1'b1;
    ff_term_enable  <= 1'b0;
    rec_term_enable <= 1'b0;
    bias_enable     <= 1'b0;
    drive_idle(1);
  endtask

  // Wait for the expected gates, then compare values and ready
  task automatic finish_test();
    int waited;
    int need;
    int i;
    need   = checked + exp_gate.size();
    waited = 0;
    while (got_gate.size() < need && waited < DRAIN_TIMEOUT) begin
      drive_idle(1);
      waited++;
    end
    if (got_gate.size() < need) begin
      $display("Timeout: only %0d of %0d gate outputs arrived",
               got_gate.size() - checked, exp_gate.size());
      test_errors++;
    end else begin
      // Extra outputs would show up here
      drive_idle(QUIET_CYCLES);
      for (i = 0; i < exp_gate.size(); i++) begin
        check_value("o_out", {16'h0, got_gate[checked + i]}, {16'h0, exp_gate[i]});
        // ready only with every L_SIZE-th gate since start
        check_value("ready", {31'h0, got_ready[checked + i]},
                    {31'h0, ((i + 1) % L_SIZE) == 0});
      end
      if (got_gate.size() > need) begin
        $display("More gate outputs than expected: %0d extra", got_gate.size() - need);
        test_errors++;
      end
    end
    if (stray_ready != stray_seen) begin
      $display("ready pulsed without o_out_enable");
      test_errors++;
    end
    checked    = got_gate.size();
    stray_seen = stray_ready;
    test_open  = 1'b0;
    report_test();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int               fd;
    int               code;
    int               id_v;
    logic             done;
    logic [7:0]       kind;
    logic [8*32-1:0]  name_v;
    logic [8*256-1:0] skip_v;
    logic [15:0]      ff_en_v;
    logic [15:0]      ff_w_v;
    logic [15:0]      ff_op_v;
    logic [15:0]      ff_last_v;
    logic [15:0]      rec_en_v;
    logic [15:0]      rec_w_v;
    logic [15:0]      rec_op_v;
    logic [15:0]      rec_last_v;
    logic [15:0]      b_en_v;
    logic [15:0]      bias_v;
    logic [15:0]      exp_v;

    void'($urandom(32'h1663146e));
    RST             = 1'b1;
    start           = 1'b0;
    ff_term_enable  = 1'b0;
    ff_term         = '0;
    rec_term_enable = 1'b0;
    rec_term        = '0;
    bias_enable     = 1'b0;
    bias_in         = '0;
    tests_passed    = 0;
    tests_failed    = 0;
    checked         = 0;
    stray_seen      = 0;
    test_open       = 1'b0;

    repeat (RESET_CYCLES) @(posedge CLK);
    RST <= 1'b0;

    // Idle outputs right after reset
    @(negedge CLK);
    test_id     = 0;
    test_name   = "reset_state";
    test_errors = 0;
    check_value("o_out_enable", {31'h0, o_out_enable}, 32'h0);
    check_value("ready", {31'h0, ready}, 32'h0);
    check_value("o_out", {16'h0, o_out}, 32'h0);
    report_test();

    fd = $fopen("tests/gate_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file tests/gate_vectors.txt");
      tests_failed++;
    end else begin
      done = 1'b0;
      while (!done) begin
        code = $fscanf(fd, " %c", kind);
        if (code != 1) begin
          done = 1'b1;
        end else if (kind == "#") begin
          code = $fgets(skip_v, fd);
        end else if (kind == "T") begin
          code = $fscanf(fd, "%d %s", id_v, name_v);
          if (test_open) begin
            finish_test();
          end
          open_test(id_v, $sformatf("%0s", name_v));
        end else if (kind == "C") begin
          code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", ff_en_v, ff_w_v, ff_op_v,
                         ff_last_v, rec_en_v, rec_w_v, rec_op_v, rec_last_v, b_en_v, bias_v);
          if (code != 10) begin
            $display("Malformed cycle record in the vector file");
            tests_failed++;
            done = 1'b1;
          end else begin
            drive_record(ff_en_v[0], ff_w_v, ff_op_v, ff_last_v[0], rec_en_v[0], rec_w_v,
                         rec_op_v, rec_last_v[0], b_en_v[0], bias_v);
            // Random idle gap of 0 to 3 cycles
            drive_idle($urandom % 4);
          end
        end else if (kind == "E") begin
          code = $fscanf(fd, "%h", exp_v);
          exp_gate.push_back(exp_v);
        end else begin
          $display("Unknown record type in the vector file");
          tests_failed++;
          done = 1'b1;
        end
      end
      if (test_open) begin
        finish_test();
      end
      $fclose(fd);
    end

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && tests_passed > 1) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- tests/gate_vectors.txt
# T <id> <name> | E <gate>, expected o_out of the next row in order (hex)
# C ff_en ff_w ff_op ff_last rec_en rec_w rec_op rec_last bias_en bias (hex)
T 1 zero_row
C 1 0100 0000 1 1 0000 0100 1 1 0000
E 0080
T 2 hard_sigmoid
C 1 0100 0080 1 1 0040 0200 1 1 0000
C 1 1000 1000 1 1 0100 0100 1 1 0200
C 1 F000 1000 1 1 0100 FF00 1 1 FE00
C 1 0100 FF00 1 1 0000 0000 1 1 0000
E 00C0
E 0100
E 0000
E 0040
T 3 skewed_rows
C 0 0000 0000 0 1 0100 0020 0 0 0000
C 0 0000 0000 0 1 0080 0040 0 0 0000
C 0 0000 0000 0 1 0200 0010 0 0 0000
C 0 0000 0000 0 1 FF00 0008 0 0 0000
C 0 0000 0000 0 1 0040 0100 1 0 0000
C 0 0000 0000 0 1 0100 0010 0 0 0000
C 0 0000 0000 0 1 0100 0010 0 0 0000
C 0 0000 0000 0 1 0100 0010 0 0 0000
C 0 0000 0000 0 1 0100 0010 0 0 0000
C 0 0000 0000 0 1 0100 FFF0 1 0 0000
C 1 0300 0020 0 0 0000 0000 0 1 0010
C 1 0100 FFE0 0 0 0000 0000 0 0 0000
C 1 0080 0080 1 0 0000 0000 0 0 0000
C 1 FE00 0040 0 0 0000 0000 0 1 FFE0
C 1 0100 0010 0 0 0000 0000 0 0 0000
C 1 0040 0040 1 0 0000 0000 0 0 0000
E 00CA
E 006C
T 4 rows_in_flight
C 1 0100 0100 0 1 0080 0100 0 1 FD00
C 1 0100 0100 1 1 0080 0100 1 0 0000
C 1 0040 0100 0 1 0100 0020 0 1 0000
C 1 0040 0100 1 1 0100 0020 1 0 0000
C 1 FF80 0100 0 1 0100 0040 0 1 0020
C 1 FF80 0100 1 1 0000 0000 1 0 0000
C 1 0200 0100 0 1 0100 0100 0 1 FF00
C 1 0100 0080 1 1 FF00 0100 1 0 0000
E 0080
E 00B0
E 0058
E 00E0
T 5 partial_vector
C 1 0100 0080 1 1 0100 0040 1 1 FFC0
C 1 0080 FF00 1 1 0000 0000 1 1 0000
C 1 7F00 7F00 0 1 7F00 7F00 0 0 0000
E 00A0
E 0060
T 6 second_start
C 1 0100 0100 1 1 0100 FF00 1 1 0000
C 1 0020 0100 1 1 0020 0100 1 1 0020
C 1 FFE0 0400 1 1 0000 0000 1 1 FFC0
C 1 0100 0100 1 1 0100 0100 1 1 0100
E 0080
E 0098
E 0050
E 0100

//--- tb.f
src/ntm_gate_pkg.sv
src/ntm_mac_row.sv
src/ntm_sum_queue.sv
src/ntm_gate_combiner.sv
src/ntm_output_gate.sv
tests/ntm_output_gate_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the NTM output gate testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module ntm_output_gate_tb \
  -f tb.f -o ntm_output_gate_sim

# Result is taken from the log
./obj_dir/ntm_output_gate_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

if ! grep -qF "*** TEST PASSED ***" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation finished without errors"
